// File: common/serdes_pkg.sv
package serdes_pkg;

    // Width of the switch and LED word buses, also the largest DATA_WIDTH
    localparam int max_data_width = 8;

    localparam int default_data_width = 8;

    // Counter bit behind the heartbeat LED on the board
    localparam int default_heartbeat_bit = 24;

    // Consecutive matching words needed before the aligner locks
    localparam int lock_count = 3;

    // Cycles the internal reset outlasts the external one
    localparam int reset_stretch = 4;

    // One word as it travels on the switch and LED buses
    typedef logic [max_data_width-1:0] word_t;

endpackage

// File: hw/clock_reset_gen.sv
module clock_reset_gen #(
    parameter int DATA_WIDTH = serdes_pkg::default_data_width
) (
    input  logic CLK,
    input  logic rst,
    output logic int_rst,
    output logic word_strobe
);

    localparam int CNT_W = $clog2(serdes_pkg::max_data_width);
    localparam logic [CNT_W-1:0] LAST_BIT = CNT_W'(DATA_WIDTH - 1);

    logic [serdes_pkg::reset_stretch-1:0] rst_sr;
    logic [CNT_W-1:0]                     bit_cnt;

    // Reset stretcher, refilled while rst is high and drained one bit per cycle
    always_ff @(posedge CLK) begin
        if (rst) begin
            rst_sr <= '1;
        end else begin
            rst_sr <= rst_sr >> 1;
        end
    end

    assign int_rst = rst | rst_sr[0]; // High at once with rst, low after the stretch

    // Bit counter replacing the divided word clock
    always_ff @(posedge CLK) begin
        if (int_rst) begin
            bit_cnt     <= '0;
            word_strobe <= 1'b0;
        end else begin
            word_strobe <= (bit_cnt == LAST_BIT); // One pulse per word
            if (bit_cnt == LAST_BIT) begin
                bit_cnt <= '0;
            end else begin
                bit_cnt <= bit_cnt + 1'b1;
            end
        end
    end

endmodule

// File: serdes/serializer.sv
module serializer #(
    parameter int DATA_WIDTH = serdes_pkg::default_data_width
) (
    input  logic              CLK,
    input  logic              int_rst,
    input  logic              word_strobe,
    input  serdes_pkg::word_t sw,
    output logic              out
);

    // Holds the word being sent, LSB goes out first
    logic [DATA_WIDTH-1:0] shift_reg;

    always_ff @(posedge CLK) begin
        if (int_rst) begin
            shift_reg <= '0; // Line idles low
        end else if (word_strobe) begin
            shift_reg <= sw[DATA_WIDTH-1:0]; // Bits above the word are dropped
        end else begin
            shift_reg <= shift_reg >> 1;
        end
    end

    // The strobe period equals the word length, so the next load follows the last bit
    assign out = shift_reg[0];

endmodule

// File: serdes/deserializer.sv
module deserializer #(
    parameter int DATA_WIDTH = serdes_pkg::default_data_width
) (
    input  logic              CLK,
    input  logic              int_rst,
    input  logic              word_strobe,
    input  logic              in,
    output serdes_pkg::word_t raw_word,
    output logic              raw_valid
);

    logic                  in_q;       // Input flop on the line
    logic [DATA_WIDTH-1:0] shift_reg;
    logic [DATA_WIDTH-1:0] shift_next;

    // Newest bit enters at the top, so the oldest ends up in bit 0
    assign shift_next = {in_q, shift_reg[DATA_WIDTH-1:1]};

    always_ff @(posedge CLK) begin
        in_q      <= in;
        shift_reg <= shift_next;
        if (word_strobe) begin
            raw_word <= serdes_pkg::word_t'(shift_next); // Last DATA_WIDTH bits
        end
    end

    always_ff @(posedge CLK) begin
        if (int_rst) begin
            raw_valid <= 1'b0;
        end else begin
            raw_valid <= word_strobe; // Lines up with the new raw_word
        end
    end

endmodule

// File: hw/word_aligner.sv
module word_aligner #(
    parameter int DATA_WIDTH = serdes_pkg::default_data_width
) (
    input  logic              CLK,
    input  logic              int_rst,
    input  serdes_pkg::word_t raw_word,
    input  logic              raw_valid,
    input  serdes_pkg::word_t sw,
    output serdes_pkg::word_t aligned_word,
    output logic              locked
);

    localparam int SLIP_W = $clog2(serdes_pkg::max_data_width);
    localparam int CNT_W  = $clog2(serdes_pkg::lock_count + 1);

    localparam serdes_pkg::word_t WIDTH_MASK = serdes_pkg::word_t'((1 << DATA_WIDTH) - 1);
    localparam logic [SLIP_W-1:0] LAST_SLIP  = SLIP_W'(DATA_WIDTH - 1);
    localparam logic [CNT_W-1:0]  LOCK_CNT   = CNT_W'(serdes_pkg::lock_count);

    logic [SLIP_W-1:0]       slip;      // Current bitslip position
    logic [CNT_W-1:0]        match_cnt;
    logic [2*DATA_WIDTH-1:0] doubled;
    serdes_pkg::word_t       rotated;
    serdes_pkg::word_t       ref_word;
    logic                    word_match;
    logic                    lock_next;

    always_comb begin
        // Two copies side by side turn the shift into a rotation
        doubled    = {raw_word[DATA_WIDTH-1:0], raw_word[DATA_WIDTH-1:0]};
        rotated    = serdes_pkg::word_t'(doubled >> slip) & WIDTH_MASK;
        ref_word   = sw & WIDTH_MASK; // Only the low DATA_WIDTH switches are sent
        word_match = (rotated == ref_word);
        lock_next  = locked || (match_cnt == LOCK_CNT - 1'b1);
    end

    always_ff @(posedge CLK) begin
        if (int_rst) begin
            slip         <= '0;
            match_cnt    <= '0;
            locked       <= 1'b0;
            aligned_word <= '0;
        end else if (raw_valid) begin
            if (word_match) begin
                if (match_cnt != LOCK_CNT) begin
                    match_cnt <= match_cnt + 1'b1; // Saturates at the threshold
                end
                if (lock_next) begin
                    locked       <= 1'b1;
                    aligned_word <= rotated; // Display changes only when locked
                end
            end else begin
                // Any bad word drops lock and tries the next bit position
                match_cnt <= '0;
                locked    <= 1'b0;
                if (slip == LAST_SLIP) begin
                    slip <= '0;
                end else begin
                    slip <= slip + 1'b1;
                end
            end
        end
    end

endmodule

// File: hw/serdes_loopback_top.sv
module serdes_loopback_top #(
    parameter int DATA_WIDTH    = serdes_pkg::default_data_width,
    parameter int HEARTBEAT_BIT = serdes_pkg::default_heartbeat_bit
) (
    input  logic              CLK,
    input  logic              rst,
    input  serdes_pkg::word_t sw,
    output logic [8:0]        led,
    input  logic              in,
    output logic              out
);

    logic              int_rst;
    logic              word_strobe;
    serdes_pkg::word_t raw_word;
    logic              raw_valid;
    serdes_pkg::word_t aligned_word;

    logic [HEARTBEAT_BIT:0] heartbeat_cnt;
    logic                   heartbeat;

    clock_reset_gen #(
        .DATA_WIDTH (DATA_WIDTH)
    ) u_clock_reset_gen (
        .CLK         (CLK),
        .rst         (rst),
        .int_rst     (int_rst),
        .word_strobe (word_strobe)
    );

    serializer #(
        .DATA_WIDTH (DATA_WIDTH)
    ) u_serializer (
        .CLK         (CLK),
        .int_rst     (int_rst),
        .word_strobe (word_strobe),
        .sw          (sw),
        .out         (out)
    );

    deserializer #(
        .DATA_WIDTH (DATA_WIDTH)
    ) u_deserializer (
        .CLK         (CLK),
        .int_rst     (int_rst),
        .word_strobe (word_strobe),
        .in          (in),
        .raw_word    (raw_word),
        .raw_valid   (raw_valid)
    );

    word_aligner #(
        .DATA_WIDTH (DATA_WIDTH)
    ) u_word_aligner (
        .CLK          (CLK),
        .int_rst      (int_rst),
        .raw_word     (raw_word),
        .raw_valid    (raw_valid),
        .sw           (sw),
        .aligned_word (aligned_word),
        .locked       () // Lock state is not brought out to a pin
    );

    // Heartbeat flips each time the counter wraps past bit HEARTBEAT_BIT
    always_ff @(posedge CLK) begin
        if (int_rst) begin
            heartbeat_cnt <= '0;
            heartbeat     <= 1'b0;
        end else begin
            heartbeat_cnt <= heartbeat_cnt + 1'b1;
            if (&heartbeat_cnt) begin
                heartbeat <= ~heartbeat;
            end
        end
    end

    assign led = {aligned_word, heartbeat}; // Word on led[8:1], heartbeat on led[0]

endmodule

// File: verification/tb_serdes_loopback.sv
module tb_serdes_loopback;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int DATA_WIDTH       = 6;
    localparam int HEARTBEAT_BIT    = 3;
    localparam int HEARTBEAT_PERIOD = 1 << (HEARTBEAT_BIT + 1); // Cycles between toggles
    localparam int MAX_DELAY        = 5;

    logic              CLK;
    logic              rst;
    logic              in;
    logic              out;
    serdes_pkg::word_t sw;
    logic [8:0]        led;

    logic [MAX_DELAY-1:0] line_q; // External loop as a chain of line flops
    int                   loop_delay;
    logic [31:0]          lcg_state;

    serdes_loopback_top #(
        .DATA_WIDTH    (DATA_WIDTH),
        .HEARTBEAT_BIT (HEARTBEAT_BIT)
    ) u_dut (
        .CLK (CLK),
        .rst (rst),
        .sw  (sw),
        .led (led),
        .in  (in),
        .out (out)
    );

    initial begin
        CLK = 1'b0;
        forever #20 CLK = ~CLK;
    end

    always @(posedge CLK) begin
        line_q <= {line_q[MAX_DELAY-2:0], out};
    end

    always_comb begin
        if (loop_delay == 0) begin
            in = out; // Straight wire back
        end else begin
            in = line_q[loop_delay-1];
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    // Only the low DATA_WIDTH switches travel over the line
    function automatic serdes_pkg::word_t mask_to_width(input serdes_pkg::word_t w);
        return w & serdes_pkg::word_t'((1 << DATA_WIDTH) - 1);
    endfunction

    function automatic serdes_pkg::word_t rotate_right(input serdes_pkg::word_t w, input int k);
        serdes_pkg::word_t r;
        r = mask_to_width(w);
        repeat (k) begin
            r = mask_to_width((r >> 1) | (serdes_pkg::word_t'(r[0]) << (DATA_WIDTH - 1)));
        end
        return r;
    endfunction

    function automatic bit has_symmetry(input serdes_pkg::word_t w);
        for (int k = 1; k < DATA_WIDTH; k++) begin
            if (rotate_right(w, k) == mask_to_width(w)) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    // Worst case slips plus lock words plus pipeline, in cycles
    function automatic int lock_bound(input int delay);
        return (DATA_WIDTH + serdes_pkg::lock_count + 2) * DATA_WIDTH + delay;
    endfunction

    task automatic stop_with_failure();
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input serdes_pkg::word_t actual,
                              input serdes_pkg::word_t expected);
        if (actual !== expected) begin
            $display("[FAIL] %s: got 0x%h, expected 0x%h", name, actual, expected);
            stop_with_failure();
        end
    endtask

    task automatic check_bit(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("[FAIL] %s: got 0x%h, expected 0x%h", name, actual, expected);
            stop_with_failure();
        end
    endtask

    // Next LCG pattern that is not rotation symmetric and differs from avoid
    task automatic draw_pattern(input serdes_pkg::word_t avoid, output serdes_pkg::word_t p);
        int tries;
        tries = 0;
        lcg_state = lcg_next(lcg_state);
        p = serdes_pkg::word_t'(lcg_state >> 16);
        while ((has_symmetry(p) || mask_to_width(p) == mask_to_width(avoid)) && tries < 32) begin
            lcg_state = lcg_next(lcg_state);
            p = serdes_pkg::word_t'(lcg_state >> 16);
            tries++;
        end
    endtask

    // Holds rst for 3 cycles and checks the idle outputs through the stretch
    task automatic apply_reset(input int delay, input serdes_pkg::word_t pattern);
        @(negedge CLK);
        rst        = 1'b1;
        sw         = pattern;
        loop_delay = delay;
        repeat (3) begin
            @(negedge CLK);
            check_bit("out", out, 1'b0);
            check_word("led[8:1]", led[8:1], '0);
        end
        rst = 1'b0;
        repeat (serdes_pkg::reset_stretch) begin
            @(negedge CLK);
            check_bit("out", out, 1'b0);
            check_bit("led[0]", led[0], 1'b0);
            check_word("led[8:1]", led[8:1], '0);
        end
    endtask

    task automatic wait_for_led(input serdes_pkg::word_t expected, input int bound);
        int cycles;
        bit seen;
        seen = 1'b0;
        for (cycles = 0; cycles < bound && !seen; cycles++) begin
            @(negedge CLK);
            if (led[8:1] === expected) begin
                seen = 1'b1;
            end
        end
        if (!seen) begin
            $display("Timeout: led[8:1] did not show 0x%h within %0d cycles", expected, bound);
            stop_with_failure();
        end
    endtask

    task automatic hold_led(input serdes_pkg::word_t expected, input int words);
        repeat (words * DATA_WIDTH) begin
            @(negedge CLK);
            check_word("led[8:1]", led[8:1], expected);
        end
    endtask

    task automatic test_reset_state();
        apply_reset(0, 8'h2D);
        @(negedge CLK);
        check_word("led[8:1]", led[8:1], '0);
    endtask

    task automatic test_lock_display();
        apply_reset(0, 8'h2D);
        wait_for_led(8'h2D, lock_bound(0));
        hold_led(8'h2D, 10);
    endtask

    task automatic test_any_delay();
        serdes_pkg::word_t p;
        for (int d = 1; d <= MAX_DELAY; d++) begin
            draw_pattern('0, p);
            apply_reset(d, p);
            wait_for_led(mask_to_width(p), lock_bound(d));
            hold_led(mask_to_width(p), 2);
        end
    endtask

    task automatic test_masking();
        apply_reset(0, 8'hFF);
        wait_for_led(8'h3F, lock_bound(0));
        hold_led(8'h3F, 2);
        apply_reset(2, 8'hC5);
        wait_for_led(8'h05, lock_bound(2));
        hold_led(8'h05, 2);
    endtask

    task automatic test_relock();
        serdes_pkg::word_t p;
        apply_reset(3, 8'h2D);
        wait_for_led(8'h2D, lock_bound(3));
        repeat (3) begin
            draw_pattern(sw, p);
            @(negedge CLK);
            sw = p; // New pattern while the aligner is locked
            wait_for_led(mask_to_width(p), lock_bound(3));
            hold_led(mask_to_width(p), 2);
        end
    endtask

    task automatic test_heartbeat();
        logic level;
        int   cycles;
        bit   toggled;
        apply_reset(0, 8'h2D);
        level   = led[0];
        toggled = 1'b0;
        for (cycles = 0; cycles < 2 * HEARTBEAT_PERIOD && !toggled; cycles++) begin
            @(negedge CLK);
            if (led[0] !== level) begin
                toggled = 1'b1;
            end
        end
        if (!toggled) begin
            $display("Timeout: heartbeat on led[0] never toggled after reset");
            stop_with_failure();
        end
        repeat (4) begin
            level = led[0];
            repeat (HEARTBEAT_PERIOD - 1) begin
                @(negedge CLK);
                check_bit("led[0]", led[0], level); // Steady between toggles
            end
            @(negedge CLK);
            check_bit("led[0]", led[0], ~level);
        end
    endtask

    initial begin
        rst        = 1'b1;
        sw         = '0;
        loop_delay = 0;
        line_q     = '0;
        lcg_state  = 32'd72;
        test_reset_state();
        test_lock_display();
        test_any_delay();
        test_masking();
        test_relock();
        test_heartbeat();
        $display("Testbench passed");
        $finish;
    end

endmodule

// File: verilog.f
common/serdes_pkg.sv
hw/clock_reset_gen.sv
serdes/serializer.sv
serdes/deserializer.sv
hw/word_aligner.sv
hw/serdes_loopback_top.sv
verification/tb_serdes_loopback.sv

// File: Bender.yml
package:
  name: serdes_loopback

sources:
  # Shared package first, then the blocks, then the top level
  - common/serdes_pkg.sv
  - hw/clock_reset_gen.sv
  - serdes/serializer.sv
  - serdes/deserializer.sv
  - hw/word_aligner.sv
  - hw/serdes_loopback_top.sv

  - target: test
    files:
      - verification/tb_serdes_loopback.sv
